/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43,
        OP_HALT  = 6'd63
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    reg_dst_rd;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc_plus4;
        word_t instr;
    } ifid_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc_plus4;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } idex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      halt;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dst;
    } exmem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      halt;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t dst;
    } memwb_t;

endpackage

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import mips_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  reg_addr_t i_rs_addr,
    input  reg_addr_t i_rt_addr,
    input  logic      i_wr_en,
    input  reg_addr_t i_wr_addr,
    input  word_t     i_wr_data,
    input  reg_addr_t i_dbg_addr,
    output word_t     o_rs_data,
    output word_t     o_rt_data,
    output word_t     o_dbg_data
);

    word_t regs [32];
    logic  wr_ok;

    // r0 is never written, so it stays at its reset value
    assign wr_ok = i_wr_en && (i_wr_addr != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Same-cycle write passes straight through
    assign o_rs_data  = (wr_ok && i_wr_addr == i_rs_addr) ? i_wr_data : regs[i_rs_addr];
    assign o_rt_data  = (wr_ok && i_wr_addr == i_rt_addr) ? i_wr_data : regs[i_rt_addr];
    assign o_dbg_data = regs[i_dbg_addr];

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import mips_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_advance,
    input  logic      i_flush,
    input  ifid_t     i_ifid,
    input  logic      i_wb_we,
    input  reg_addr_t i_wb_addr,
    input  word_t     i_wb_data,
    input  reg_addr_t i_dbg_reg_addr,
    output logic      o_stall,
    output idex_t     o_idex,
    output word_t     o_dbg_reg_data
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     rs_data;
    word_t     rt_data;
    ctrl_t     ctrl;
    logic      uses_rt;
    idex_t     idex_d;
    idex_t     idex_q;

    assign opcode = opcode_e'(i_ifid.instr[31:26]);
    assign funct  = funct_e'(i_ifid.instr[5:0]);
    assign rs     = i_ifid.instr[25:21];
    assign rt     = i_ifid.instr[20:16];
    assign rd     = i_ifid.instr[15:11];

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs_addr  (rs),
        .i_rt_addr  (rt),
        .i_wr_en    (i_wb_we && i_advance),
        .i_wr_addr  (i_wb_addr),
        .i_wr_data  (i_wb_data),
        .i_dbg_addr (i_dbg_reg_addr),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_reg_data)
    );

    always_comb begin
        ctrl    = '0;
        uses_rt = 1'b0;
        if (i_ifid.valid) begin
            case (opcode)
                OP_RTYPE: begin
                    ctrl.reg_dst_rd = 1'b1;
                    ctrl.reg_write  = 1'b1;
                    uses_rt         = 1'b1;
                    case (funct)
                        FN_ADD:  ctrl.alu_op = ALU_ADD;
                        FN_SUB:  ctrl.alu_op = ALU_SUB;
                        FN_AND:  ctrl.alu_op = ALU_AND;
                        FN_OR:   ctrl.alu_op = ALU_OR;
                        FN_SLT:  ctrl.alu_op = ALU_SLT;
                        default: ctrl = '0;
                    endcase
                end
                OP_ADDI: begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.reg_write   = 1'b1;
                end
                OP_LW: begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                end
                OP_SW: begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_write   = 1'b1;
                    uses_rt          = 1'b1;
                end
                OP_BEQ, OP_BNE: begin
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = (opcode == OP_BNE);
                    uses_rt        = 1'b1;
                end
                OP_HALT: ctrl.halt = 1'b1;
                default: ctrl = '0;
            endcase
        end
    end

    // Load in EX whose result is needed here
    assign o_stall = i_ifid.valid && idex_q.ctrl.mem_read && (idex_q.rt != '0) &&
                     ((idex_q.rt == rs) || (uses_rt && (idex_q.rt == rt)));

    always_comb begin
        idex_d.ctrl     = (i_flush || o_stall) ? '0 : ctrl;
        idex_d.pc_plus4 = i_ifid.pc_plus4;
        idex_d.rs_data  = rs_data;
        idex_d.rt_data  = rt_data;
        idex_d.imm      = {{16{i_ifid.instr[15]}}, i_ifid.instr[15:0]};
        idex_d.rs       = rs;
        idex_d.rt       = rt;
        idex_d.rd       = rd;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idex_q <= '0;
        end else if (i_advance) begin
            idex_q <= idex_d;
        end
    end

    assign o_idex = idex_q;

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import mips_pkg::*;
#(
    parameter int IMEM_DEPTH = 256
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_advance,
    input  logic       i_stall,
    input  logic       i_redirect,
    input  word_t      i_target,
    input  logic       i_imem_we,
    input  logic [7:0] i_imem_addr,
    input  word_t      i_imem_data,
    output word_t      o_pc,
    output ifid_t      o_ifid
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];
    word_t pc_q;
    word_t pc_plus4;
    ifid_t ifid_q;

    // Load port, used while the core is held
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    assign pc_plus4 = pc_q + 32'd4;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q   <= '0;
            ifid_q <= '0;
        end else if (i_advance) begin
            if (i_redirect) begin
                // Taken branch kills the word in IF/ID
                pc_q   <= i_target;
                ifid_q <= '0;
            end else if (!i_stall) begin
                pc_q            <= pc_plus4;
                ifid_q.valid    <= 1'b1;
                ifid_q.pc_plus4 <= pc_plus4;
                ifid_q.instr    <= imem[pc_q[IMEM_AW+1:2]];
            end
        end
    end

    assign o_pc   = pc_q;
    assign o_ifid = ifid_q;

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import mips_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_advance,
    input  idex_t     i_idex,
    input  logic      i_wb_we,
    input  reg_addr_t i_wb_addr,
    input  word_t     i_wb_data,
    output logic      o_redirect,
    output word_t     o_target,
    output exmem_t    o_exmem
);

    exmem_t   exmem_q;
    exmem_t   exmem_d;
    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    word_t    op_a;
    word_t    rt_fwd;
    word_t    op_b;
    word_t    alu_result;
    logic     equal;

    // EX/MEM is newer than MEM/WB, so it wins
    function automatic fwd_sel_e pick_src(input reg_addr_t src);
        if (src == '0) begin
            return FWD_REG;
        end else if (exmem_q.reg_write && exmem_q.dst == src) begin
            return FWD_EXMEM;
        end else if (i_wb_we && i_wb_addr == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    function automatic word_t fwd_value(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_EXMEM: return exmem_q.alu_result;
            FWD_MEMWB: return i_wb_data;
            default:   return reg_val;
        endcase
    endfunction

    assign sel_a  = pick_src(i_idex.rs);
    assign sel_b  = pick_src(i_idex.rt);
    assign op_a   = fwd_value(sel_a, i_idex.rs_data);
    assign rt_fwd = fwd_value(sel_b, i_idex.rt_data);
    assign op_b   = i_idex.ctrl.alu_src_imm ? i_idex.imm : rt_fwd;

    always_comb begin
        case (i_idex.ctrl.alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    // Branch resolved here, two younger slots get flushed
    assign equal      = (op_a == rt_fwd);
    assign o_redirect = i_idex.ctrl.branch && (equal != i_idex.ctrl.branch_ne);
    assign o_target   = i_idex.pc_plus4 + {i_idex.imm[29:0], 2'b00};

    always_comb begin
        exmem_d.reg_write  = i_idex.ctrl.reg_write;
        exmem_d.mem_read   = i_idex.ctrl.mem_read;
        exmem_d.mem_write  = i_idex.ctrl.mem_write;
        exmem_d.halt       = i_idex.ctrl.halt;
        exmem_d.alu_result = alu_result;
        exmem_d.store_data = rt_fwd;
        exmem_d.dst        = i_idex.ctrl.reg_dst_rd ? i_idex.rd : i_idex.rt;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            exmem_q <= '0;
        end else if (i_advance) begin
            exmem_q <= exmem_d;
        end
    end

    assign o_exmem = exmem_q;

endmodule

`default_nettype wire

/* hw/mem_wb_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage
    import mips_pkg::*;
#(
    parameter int DMEM_DEPTH = 1024
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_advance,
    input  exmem_t                        i_exmem,
    input  logic [$clog2(DMEM_DEPTH)-1:0] i_dbg_mem_addr,
    output logic                          o_wb_we,
    output reg_addr_t                     o_wb_addr,
    output word_t                         o_wb_data,
    output logic                          o_halt,
    output word_t                         o_dbg_mem_data
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    word_t                dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0]   word_idx;
    word_t                load_data;
    memwb_t               memwb_q;
    logic                 halt_q;

    // Word addressed, byte offset ignored
    assign word_idx  = i_exmem.alu_result[DMEM_AW+1:2];
    assign load_data = dmem[word_idx];

    always_ff @(posedge i_clk) begin
        if (i_advance && i_exmem.mem_write) begin
            dmem[word_idx] <= i_exmem.store_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            memwb_q <= '0;
        end else if (i_advance) begin
            memwb_q.reg_write  <= i_exmem.reg_write;
            memwb_q.mem_to_reg <= i_exmem.mem_read;
            memwb_q.halt       <= i_exmem.halt;
            memwb_q.alu_result <= i_exmem.alu_result;
            memwb_q.load_data  <= load_data;
            memwb_q.dst        <= i_exmem.dst;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halt_q <= 1'b0;
        end else if (memwb_q.halt) begin
            halt_q <= 1'b1;
        end
    end

    // High from the edge HALT lands in MEM/WB
    assign o_halt = memwb_q.halt || halt_q;

    assign o_wb_we        = memwb_q.reg_write && (memwb_q.dst != '0);
    assign o_wb_addr      = memwb_q.dst;
    assign o_wb_data      = memwb_q.mem_to_reg ? memwb_q.load_data : memwb_q.alu_result;
    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

endmodule

`default_nettype wire

/* hw/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_core
    import mips_pkg::*;
#(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 1024
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_run,
    input  logic                          i_imem_we,
    input  logic [7:0]                    i_imem_addr,
    input  word_t                         i_imem_data,
    input  reg_addr_t                     i_dbg_reg_addr,
    input  logic [$clog2(DMEM_DEPTH)-1:0] i_dbg_mem_addr,
    output word_t                         o_pc,
    output logic                          o_halt,
    output word_t                         o_dbg_reg_data,
    output word_t                         o_dbg_mem_data
);

    logic      advance;
    logic      stall;
    logic      redirect;
    word_t     target;
    ifid_t     ifid;
    idex_t     idex;
    exmem_t    exmem;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    // Whole pipeline moves together or not at all
    assign advance = i_run && !o_halt;

    fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_advance   (advance),
        .i_stall     (stall),
        .i_redirect  (redirect),
        .i_target    (target),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_pc        (o_pc),
        .o_ifid      (ifid)
    );

    decode_stage u_decode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_advance      (advance),
        .i_flush        (redirect),
        .i_ifid         (ifid),
        .i_wb_we        (wb_we),
        .i_wb_addr      (wb_addr),
        .i_wb_data      (wb_data),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_stall        (stall),
        .o_idex         (idex),
        .o_dbg_reg_data (o_dbg_reg_data)
    );

    execute_stage u_execute (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_advance  (advance),
        .i_idex     (idex),
        .i_wb_we    (wb_we),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_data),
        .o_redirect (redirect),
        .o_target   (target),
        .o_exmem    (exmem)
    );

    mem_wb_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_mem_wb (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_advance      (advance),
        .i_exmem        (exmem),
        .i_dbg_mem_addr (i_dbg_mem_addr),
        .o_wb_we        (wb_we),
        .o_wb_addr      (wb_addr),
        .o_wb_data      (wb_data),
        .o_halt         (o_halt),
        .o_dbg_mem_data (o_dbg_mem_data)
    );

endmodule

`default_nettype wire

/* dv/tb_mips.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mips;

    localparam int    CLK_PERIOD = 4;
    localparam string STIM_FILE  = "dv/mips_stimulus.txt";

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        imem_we;
    logic [7:0]  imem_addr;
    logic [31:0] imem_data;
    logic [4:0]  dbg_reg_addr;
    logic [9:0]  dbg_mem_addr;
    logic [31:0] pc;
    logic        halt;
    logic [31:0] dbg_reg_data;
    logic [31:0] dbg_mem_data;

    logic [31:0] prog_words [$];
    logic [4:0]  reg_idx [$];
    logic [31:0] reg_val [$];
    logic [9:0]  mem_idx [$];
    logic [31:0] mem_val [$];

    int   checks;
    int   errors;
    logic stim_loaded;

    mips_core dut (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_run          (run),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .i_dbg_reg_addr (dbg_reg_addr),
        .i_dbg_mem_addr (dbg_mem_addr),
        .o_pc           (pc),
        .o_halt         (halt),
        .o_dbg_reg_data (dbg_reg_data),
        .o_dbg_mem_data (dbg_mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Tags P, R and M; anything else runs to end of line
    task automatic read_stimulus();
        int               fd;
        int               n;
        logic             done;
        logic [7:0]       tag;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [8*128-1:0] rest;
        done = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: could not open %s", STIM_FILE);
            done = 1'b1;
        end
        while (!done) begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1) begin
                done = 1'b1;
            end else if (tag == "P") begin
                n = $fscanf(fd, "%h", a);
                prog_words.push_back(a);
            end else if (tag == "R") begin
                n = $fscanf(fd, "%h %h", a, b);
                reg_idx.push_back(a[4:0]);
                reg_val.push_back(b);
            end else if (tag == "M") begin
                n = $fscanf(fd, "%h %h", a, b);
                mem_idx.push_back(a[9:0]);
                mem_val.push_back(b);
            end else begin
                n = $fgets(rest, fd);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    function automatic int find_halt_index();
        for (int i = 0; i < prog_words.size(); i++) begin
            if (prog_words[i][31:26] == 6'h3f) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic run_tests();
        logic [31:0] halt_pc;
        logic [4:0]  r;
        // HALT takes four more fetches to reach MEM/WB
        halt_pc = 32'(find_halt_index() + 4) * 32'd4;
        for (int i = 0; i < prog_words.size(); i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= 8'(i);
            imem_data <= prog_words[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        run     <= 1'b1;
        while (halt !== 1'b1) begin
            @(negedge clk);
        end
        // Frozen core, registers read back in turn
        for (int k = 0; k < 10; k++) begin
            r = reg_idx[k % reg_idx.size()];
            @(posedge clk);
            dbg_reg_addr <= r;
            @(negedge clk);
            check_word("o_pc", halt_pc, pc);
            check_word("o_halt", 32'd1, {31'd0, halt});
            check_word($sformatf("o_dbg_reg_data[r%0d]", r), reg_val[k % reg_val.size()],
                       dbg_reg_data);
        end
        for (int i = 0; i < reg_idx.size(); i++) begin
            @(posedge clk);
            dbg_reg_addr <= reg_idx[i];
            @(negedge clk);
            check_word($sformatf("o_dbg_reg_data[r%0d]", reg_idx[i]), reg_val[i], dbg_reg_data);
        end
        for (int i = 0; i < mem_idx.size(); i++) begin
            @(posedge clk);
            dbg_mem_addr <= mem_idx[i];
            @(negedge clk);
            check_word($sformatf("o_dbg_mem_data[%0d]", mem_idx[i]), mem_val[i], dbg_mem_data);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin : main
        checks       = 0;
        errors       = 0;
        stim_loaded  = 1'b0;
        rst_n        = 1'b0;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_addr = '0;
        dbg_mem_addr = '0;
        read_stimulus();
        stim_loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("o_pc", 32'd0, pc);
        check_word("o_halt", 32'd0, {31'd0, halt});
        if (prog_words.size() == 0 || reg_idx.size() == 0) begin
            $display("ERROR: stimulus file holds no program or no expected registers");
            errors++;
        end else begin
            run_tests();
        end
        finish_run();
    end

    initial begin : watchdog
        int limit;
        wait (stim_loaded === 1'b1);
        limit = 40 * prog_words.size() + 100;
        repeat (limit) @(posedge clk);
        $display("ERROR: timeout, halt was never reached within %0d cycles", limit);
        errors++;
        finish_run();
    end

endmodule

`default_nettype wire

/* dv/mips_stimulus.txt */
# P <instruction>, R <register index> <value>, M <data word index> <value>
# All fields hex; program words load from word 0 upward
P 20010005  # addi r1, r0, 5
P 2022fffd  # addi r2, r1, -3
P 00221820  # add  r3, r1, r2
P 00612022  # sub  r4, r3, r1
P 00642824  # and  r5, r3, r4
P 00a13025  # or   r6, r5, r1
P 2009ffff  # addi r9, r0, -1
P 0043382a  # slt  r7, r2, r3
P 0121402a  # slt  r8, r9, r1
P 0029502a  # slt  r10, r1, r9
P 20200009  # addi r0, r1, 9
P 00015820  # add  r11, r0, r1
P ac030008  # sw   r3, 8(r0)
P 8c0c0008  # lw   r12, 8(r0)
P 01816820  # add  r13, r12, r1
P ac0d0004  # sw   r13, 4(r0)
P 102b0001  # beq  r1, r11, +1
P 200e0063  # skipped
P 142b0001  # bne  r1, r11, +1
P 200f0021  # addi r15, r0, 33
P 14220002  # bne  r1, r2, +2
P 2010002c  # skipped
P 20110037  # skipped
P 20120042  # addi r18, r0, 66
P fc000000  # halt
R 00 00000000
R 01 00000005
R 02 00000002
R 03 00000007
R 04 00000002
R 05 00000002
R 06 00000007
R 07 00000001
R 08 00000001
R 09 ffffffff
R 0a 00000000
R 0b 00000005
R 0c 00000007
R 0d 0000000c
R 0e 00000000
R 0f 00000021
R 10 00000000
R 11 00000000
R 12 00000042
M 001 0000000c
M 002 00000007

/* vlog.f */
common/mips_pkg.sv
decode/reg_file.sv
decode/decode_stage.sv
hw/fetch_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/mips_core.sv
dv/tb_mips.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - common/mips_pkg.sv
  - decode/reg_file.sv
  - decode/decode_stage.sv
  - hw/fetch_stage.sv
  - hw/execute_stage.sv
  - hw/mem_wb_stage.sv
  - hw/mips_core.sv
  - target: simulation
    files:
      - dv/tb_mips.sv
